//--- logic/riscv_div_isa_pkg.sv
// riscv divide isa package: instruction fields, M-extension encodings, divide op codes
`default_nettype none

package riscv_div_isa_pkg;

  //////////////////////////////
  // instruction fields
  //////////////////////////////
  typedef logic [31:0] instr_t;   // full instruction word
  typedef logic [ 4:0] opcode_t;  // opcode[6:2], low bits always 2'b11
  typedef logic [ 2:0] funct3_t;
  typedef logic [ 6:0] funct7_t;

  //////////////////////////////
  // encodings
  //////////////////////////////
  localparam opcode_t OPC_OP    = 5'b01100;  // register-register ops
  localparam opcode_t OPC_OP_64 = 5'b01110;  // OP-32, word forms (not decoded by the divider)

  localparam funct7_t FUNCT7_MULDIV = 7'b0000001;  // M extension

  // divide group lives in the upper half of funct3
  localparam funct3_t F3_DIV  = 3'b100;
  localparam funct3_t F3_DIVU = 3'b101;
  localparam funct3_t F3_REM  = 3'b110;
  localparam funct3_t F3_REMU = 3'b111;

  // operation code, same order as funct3[1:0]
  typedef enum logic [1:0]
  {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10,
    OP_REMU = 2'b11
  } div_op_e;

endpackage

`default_nettype wire

//--- logic/riscv_div_ctl_pkg.sv
// riscv divide control package: fsm states and the per-operation control bundle
`default_nettype none

package riscv_div_ctl_pkg;

  //////////////////////////////
  // fsm states
  //////////////////////////////
  typedef enum logic [1:0]
  {
    ST_CHK = 2'b00,  // idle, check incoming instr
    ST_DIV = 2'b01,  // iterating
    ST_RES = 2'b10   // format and write result
  } div_state_e;

  //////////////////////////////
  // control bundle
  //////////////////////////////
  // captured at acceptance, used once the core is done
  typedef struct packed
  {
    logic is_rem;  // remainder instead of quotient
    logic neg_q;   // quotient sign fix
    logic neg_r;   // remainder sign fix
  } div_ctl_t;

endpackage

`default_nettype wire

//--- logic/riscv_div_decode.sv
// divide decoder: finds div/rem ops, answers special cases, forms magnitudes and sign flags
`default_nettype none

module riscv_div_decode #(
  parameter int XLEN = 32
)
(
  input  wire riscv_div_isa_pkg::instr_t  id_instr,
  input  wire logic [XLEN-1:0]            op_a,
  input  wire logic [XLEN-1:0]            op_b,
  output logic                            is_div,
  output logic                            special,
  output logic [XLEN-1:0]                 special_val,
  output riscv_div_ctl_pkg::div_ctl_t     ctl,
  output logic [XLEN-1:0]                 mag_a,
  output logic [XLEN-1:0]                 mag_b
);

  typedef logic [XLEN-1:0] xword_t;

  localparam xword_t MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};  // -2^(XLEN-1)

  riscv_div_isa_pkg::opcode_t opcode;
  riscv_div_isa_pkg::funct3_t funct3;
  riscv_div_isa_pkg::funct7_t funct7;
  riscv_div_isa_pkg::div_op_e op;
  logic                       f3_ok;     // funct3 is one of the divide group
  logic                       is_signed;
  logic                       div_zero;
  logic                       ovf;

  // field extraction
  assign opcode = id_instr[6:2];
  assign funct3 = id_instr[14:12];
  assign funct7 = id_instr[31:25];

  always_comb
  begin
    op    = riscv_div_isa_pkg::OP_DIV;
    f3_ok = 1'b1;
    case (funct3)
      riscv_div_isa_pkg::F3_DIV:  op = riscv_div_isa_pkg::OP_DIV;
      riscv_div_isa_pkg::F3_DIVU: op = riscv_div_isa_pkg::OP_DIVU;
      riscv_div_isa_pkg::F3_REM:  op = riscv_div_isa_pkg::OP_REM;
      riscv_div_isa_pkg::F3_REMU: op = riscv_div_isa_pkg::OP_REMU;
      default:                    f3_ok = 1'b0;  // mul group
    endcase
  end

  assign is_div = (id_instr[1:0] == 2'b11) && (opcode == riscv_div_isa_pkg::OPC_OP) &&
                  (funct7 == riscv_div_isa_pkg::FUNCT7_MULDIV) && f3_ok;

  assign is_signed = (op == riscv_div_isa_pkg::OP_DIV) || (op == riscv_div_isa_pkg::OP_REM);

  // special cases
  assign div_zero = ~|op_b;
  assign ovf      = is_signed && (op_a == MOST_NEG) && (&op_b);  // -2^(XLEN-1) / -1
  assign special  = is_div && (div_zero || ovf);

  // control flags, sign fix only for signed ops
  assign ctl.is_rem = (op == riscv_div_isa_pkg::OP_REM) || (op == riscv_div_isa_pkg::OP_REMU);
  assign ctl.neg_q  = is_signed && (op_a[XLEN-1] ^ op_b[XLEN-1]);
  assign ctl.neg_r  = is_signed && op_a[XLEN-1];  // remainder follows dividend

  // isa answers
  always_comb
  begin
    if (div_zero)
      special_val = ctl.is_rem ? op_a : '1;     // rem = dividend, quot = all ones
    else
      special_val = ctl.is_rem ? '0 : MOST_NEG;  // overflow
  end

  // magnitudes
  assign mag_a = (is_signed && op_a[XLEN-1]) ? (~op_a + 1'b1) : op_a;
  assign mag_b = (is_signed && op_b[XLEN-1]) ? (~op_b + 1'b1) : op_b;

endmodule

`default_nettype wire

//--- logic/riscv_div_fsm.sv
// divide control fsm: acceptance, step sequencing, stall and bubble strobes
`default_nettype none

module riscv_div_fsm
(
  input  wire  clk,
  input  wire  rstn,
  input  wire  ex_stall,
  input  wire  id_bubble,
  input  wire  is_div,
  input  wire  special,
  input  wire  last,
  output logic start,
  output logic take_special,
  output logic step,
  output logic finish,
  output logic div_stall,
  output logic div_bubble
);

  riscv_div_ctl_pkg::div_state_e state_q;
  logic                          accept;

  //////////////////////////////
  // strobes
  //////////////////////////////
  assign accept = (state_q == riscv_div_ctl_pkg::ST_CHK) && !ex_stall && !id_bubble && is_div;

  assign take_special = accept && special;   // one-cycle answer
  assign start        = accept && !special;  // launch iteration
  assign step         = (state_q == riscv_div_ctl_pkg::ST_DIV);
  assign finish       = (state_q == riscv_div_ctl_pkg::ST_RES);

  //////////////////////////////
  // state and pipeline flags
  //////////////////////////////
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state_q    <= riscv_div_ctl_pkg::ST_CHK;
      div_stall  <= 1'b0;
      div_bubble <= 1'b1;
    end
    else
    begin
      div_bubble <= !(take_special || finish);  // low for one cycle per result

      case (state_q)
        riscv_div_ctl_pkg::ST_CHK:
          if (start)
          begin
            state_q   <= riscv_div_ctl_pkg::ST_DIV;
            div_stall <= 1'b1;
          end
        riscv_div_ctl_pkg::ST_DIV:
          if (step && last)
            state_q <= riscv_div_ctl_pkg::ST_RES;  // final step this cycle
        riscv_div_ctl_pkg::ST_RES:
        begin
          state_q   <= riscv_div_ctl_pkg::ST_CHK;
          div_stall <= 1'b0;
        end
        default:
          state_q <= riscv_div_ctl_pkg::ST_CHK;
      endcase
    end
  end

  // stall must never leak into idle
  a_no_stall_idle: assert property (@(posedge clk) disable iff (!rstn)
    (state_q == riscv_div_ctl_pkg::ST_CHK) |-> !div_stall)
    else $error("fsm: stall high while idle");

endmodule

`default_nettype wire

//--- logic/riscv_div_step_counter.sv
// divide step counter: times the XLEN shift-subtract steps
`default_nettype none

module riscv_div_step_counter #(
  parameter int XLEN = 32
)
(
  input  wire  clk,
  input  wire  rstn,
  input  wire  start,
  input  wire  step,
  output logic last
);

  localparam int CNT_W = $clog2(XLEN);

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t cnt_q;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      cnt_q <= '0;
    else if (start)
      cnt_q <= cnt_t'(XLEN - 1);  // XLEN steps down to zero
    else if (step)
      cnt_q <= cnt_q - 1'b1;
  end

  assign last = (cnt_q == '0);

  a_start_not_step: assert property (@(posedge clk) disable iff (!rstn) !(start && step))
    else $error("counter: start while stepping");

endmodule

`default_nettype wire

//--- logic/riscv_div_restoring_core.sv
// restoring divide core: partial remainder and quotient shift-subtract datapath
`default_nettype none

module riscv_div_restoring_core #(
  parameter int XLEN = 32
)
(
  input  wire             clk,
  input  wire             rstn,
  input  wire             start,
  input  wire             step,
  input  wire [XLEN-1:0]  mag_a,
  input  wire [XLEN-1:0]  mag_b,
  output logic [XLEN-1:0] quot,
  output logic [XLEN-1:0] rem
);

  typedef logic [XLEN-1:0] xword_t;

  xword_t          p_q;    // partial remainder
  xword_t          a_q;    // dividend in, quotient out
  xword_t          b_q;    // divisor
  logic [XLEN:0]   p_sh;   // remainder after shift, one extra bit
  logic [XLEN+1:0] trial;  // trial subtract, msb is borrow

  //////////////////////////////
  // trial subtract
  //////////////////////////////
  assign p_sh  = {p_q, a_q[XLEN-1]};
  assign trial = {1'b0, p_sh} - {2'b00, b_q};

  // load on start, one shift-subtract per step
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      p_q <= '0;
      a_q <= mag_a;
      b_q <= mag_b;
    end
    else if (step)
    begin
      if (trial[XLEN+1])
      begin
        p_q <= p_sh[XLEN-1:0];           // restore
        a_q <= {a_q[XLEN-2:0], 1'b0};    // q bit 0
      end
      else
      begin
        p_q <= trial[XLEN-1:0];          // keep difference
        a_q <= {a_q[XLEN-2:0], 1'b1};    // q bit 1
      end
    end
  end

  assign quot = a_q;
  assign rem  = p_q;

  // decode must have diverted zero divisors
  a_divisor_nonzero: assert property (@(posedge clk) disable iff (!rstn)
    start |-> (mag_b != '0))
    else $error("core: started with zero divisor");

endmodule

`default_nettype wire

//--- logic/riscv_div_result.sv
// divide result stage: latches control, formats and registers the final value
`default_nettype none

module riscv_div_result #(
  parameter int XLEN = 32
)
(
  input  wire                              clk,
  input  wire                              rstn,
  input  wire                              start,
  input  wire                              take_special,
  input  wire                              finish,
  input  wire riscv_div_ctl_pkg::div_ctl_t ctl,
  input  wire logic [XLEN-1:0]             special_val,
  input  wire logic [XLEN-1:0]             quot,
  input  wire logic [XLEN-1:0]             rem,
  output logic [XLEN-1:0]                  div_r
);

  typedef logic [XLEN-1:0] xword_t;

  riscv_div_ctl_pkg::div_ctl_t ctl_q;
  xword_t                      q_fmt;
  xword_t                      r_fmt;

  // flags held across the iteration
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      ctl_q <= '0;
    else if (start)
      ctl_q <= ctl;
  end

  //////////////////////////////
  // sign fix
  //////////////////////////////
  assign q_fmt = ctl_q.neg_q ? (~quot + 1'b1) : quot;  // truncate toward zero
  assign r_fmt = ctl_q.neg_r ? (~rem + 1'b1) : rem;

  // holds between results
  always_ff @(posedge clk)
  begin
    if (take_special)
      div_r <= special_val;
    else if (finish)
      div_r <= ctl_q.is_rem ? r_fmt : q_fmt;
  end

endmodule

`default_nettype wire

//--- logic/riscv_div_top.sv
// riscv divider top level: bit-serial restoring DIV/DIVU/REM/REMU unit
`default_nettype none

module riscv_div_top #(
  parameter int XLEN = 32
)
(
  input  wire                            clk,
  input  wire                            rstn,
  input  wire                            ex_stall,
  input  wire                            id_bubble,
  input  wire riscv_div_isa_pkg::instr_t id_instr,
  input  wire logic [XLEN-1:0]           op_a,
  input  wire logic [XLEN-1:0]           op_b,
  output logic                           div_stall,
  output logic                           div_bubble,
  output logic [XLEN-1:0]                div_r
);

  // decode outputs
  logic                        is_div;
  logic                        special;
  logic [XLEN-1:0]             special_val;
  riscv_div_ctl_pkg::div_ctl_t ctl;
  logic [XLEN-1:0]             mag_a;
  logic [XLEN-1:0]             mag_b;

  // sequencing
  logic start;
  logic take_special;
  logic step;
  logic finish;
  logic last;

  // core results, unsigned
  logic [XLEN-1:0] quot;
  logic [XLEN-1:0] rem;

  //////////////////////////////
  // instances
  //////////////////////////////
  riscv_div_decode #(.XLEN(XLEN)) u_decode (
    .id_instr    (id_instr),
    .op_a        (op_a),
    .op_b        (op_b),
    .is_div      (is_div),
    .special     (special),
    .special_val (special_val),
    .ctl         (ctl),
    .mag_a       (mag_a),
    .mag_b       (mag_b)
  );

  riscv_div_fsm u_fsm (
    .clk          (clk),
    .rstn         (rstn),
    .ex_stall     (ex_stall),
    .id_bubble    (id_bubble),
    .is_div       (is_div),
    .special      (special),
    .last         (last),
    .start        (start),
    .take_special (take_special),
    .step         (step),
    .finish       (finish),
    .div_stall    (div_stall),
    .div_bubble   (div_bubble)
  );

  riscv_div_step_counter #(.XLEN(XLEN)) u_counter (
    .clk   (clk),
    .rstn  (rstn),
    .start (start),
    .step  (step),
    .last  (last)
  );

  riscv_div_restoring_core #(.XLEN(XLEN)) u_core (
    .clk   (clk),
    .rstn  (rstn),
    .start (start),
    .step  (step),
    .mag_a (mag_a),
    .mag_b (mag_b),
    .quot  (quot),
    .rem   (rem)
  );

  riscv_div_result #(.XLEN(XLEN)) u_result (
    .clk          (clk),
    .rstn         (rstn),
    .start        (start),
    .take_special (take_special),
    .finish       (finish),
    .ctl          (ctl),
    .special_val  (special_val),
    .quot         (quot),
    .rem          (rem),
    .div_r        (div_r)
  );

endmodule

`default_nettype wire

//--- include/riscv_div_tb_cases.svh
// divider directed cases: name, operation, dividend, divisor, expected div_r
`ifndef RISCV_DIV_TB_CASES_SVH
`define RISCV_DIV_TB_CASES_SVH

  // columns: name, op, op_a, op_b, expected
  task automatic load_directed_cases();
    // unsigned
    add_case("divu_basic", riscv_div_isa_pkg::OP_DIVU, 32'd100, 32'd7, 32'd14);
    add_case("remu_basic", riscv_div_isa_pkg::OP_REMU, 32'd100, 32'd7, 32'd2);
    add_case("divu_small", riscv_div_isa_pkg::OP_DIVU, 32'd5, 32'd9, 32'd0);
    add_case("remu_small", riscv_div_isa_pkg::OP_REMU, 32'd5, 32'd9, 32'd5);
    add_case("divu_big", riscv_div_isa_pkg::OP_DIVU, 32'hffff_ffff, 32'h10, 32'h0fff_ffff);
    add_case("remu_big", riscv_div_isa_pkg::OP_REMU, 32'hffff_ffff, 32'h10, 32'hf);
    add_case("divu_minneg", riscv_div_isa_pkg::OP_DIVU, 32'h8000_0000, 32'hffff_ffff, 32'h0);
    add_case("remu_minneg", riscv_div_isa_pkg::OP_REMU, 32'h8000_0000, 32'hffff_ffff,
             32'h8000_0000);
    add_case("divu_by_one", riscv_div_isa_pkg::OP_DIVU, 32'hcafe_f00d, 32'd1, 32'hcafe_f00d);
    // signed, all four sign pairs (-7 and -2)
    add_case("div_pp", riscv_div_isa_pkg::OP_DIV, 32'd7, 32'd2, 32'd3);
    add_case("div_np", riscv_div_isa_pkg::OP_DIV, 32'hffff_fff9, 32'd2, 32'hffff_fffd);
    add_case("div_pn", riscv_div_isa_pkg::OP_DIV, 32'd7, 32'hffff_fffe, 32'hffff_fffd);
    add_case("div_nn", riscv_div_isa_pkg::OP_DIV, 32'hffff_fff9, 32'hffff_fffe, 32'd3);
    add_case("rem_pp", riscv_div_isa_pkg::OP_REM, 32'd7, 32'd2, 32'd1);
    add_case("rem_np", riscv_div_isa_pkg::OP_REM, 32'hffff_fff9, 32'd2, 32'hffff_ffff);
    add_case("rem_pn", riscv_div_isa_pkg::OP_REM, 32'd7, 32'hffff_fffe, 32'd1);
    add_case("rem_nn", riscv_div_isa_pkg::OP_REM, 32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff);
    add_case("div_min_by_2", riscv_div_isa_pkg::OP_DIV, 32'h8000_0000, 32'd2, 32'hc000_0000);
    add_case("div_neg_exact", riscv_div_isa_pkg::OP_DIV, 32'hffff_ff9c, 32'd10, 32'hffff_fff6);
    add_case("rem_min_by_3", riscv_div_isa_pkg::OP_REM, 32'h8000_0000, 32'd3, 32'hffff_fffe);
    // divide by zero
    add_case("div_zero", riscv_div_isa_pkg::OP_DIV, 32'h1234_5678, 32'd0, 32'hffff_ffff);
    add_case("divu_zero", riscv_div_isa_pkg::OP_DIVU, 32'hdead_beef, 32'd0, 32'hffff_ffff);
    add_case("rem_zero", riscv_div_isa_pkg::OP_REM, 32'h8765_4321, 32'd0, 32'h8765_4321);
    add_case("remu_zero", riscv_div_isa_pkg::OP_REMU, 32'h42, 32'd0, 32'h42);
    // signed overflow
    add_case("div_ovf", riscv_div_isa_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    add_case("rem_ovf", riscv_div_isa_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff, 32'h0);
  endtask

`endif

//--- test/riscv_div_tb.sv
// divider testbench: directed table, seeded random cases, result and timing checks
`default_nettype none

module riscv_div_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};  // -2^(XLEN-1)

  // one stimulus row, name kept apart
  typedef struct packed
  {
    riscv_div_isa_pkg::div_op_e op;
    logic [XLEN-1:0]            a;
    logic [XLEN-1:0]            b;
    logic [XLEN-1:0]            exp;
  } vec_t;

  logic                      clk;
  logic                      rstn;
  logic                      ex_stall;
  logic                      id_bubble;
  riscv_div_isa_pkg::instr_t id_instr;
  logic [XLEN-1:0]           op_a;
  logic [XLEN-1:0]           op_b;
  logic                      div_stall;
  logic                      div_bubble;
  logic [XLEN-1:0]           div_r;

  vec_t            vecs[$];
  string           vec_names[$];
  logic [XLEN-1:0] last_r;    // value div_r should be holding
  int              n_checks;
  int              n_errors;
  logic            loaded;    // table ready, watchdog may size itself

  riscv_div_top #(.XLEN(XLEN)) uut (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .op_a       (op_a),
    .op_b       (op_b),
    .div_stall  (div_stall),
    .div_bubble (div_bubble),
    .div_r      (div_r)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  task automatic add_case(input string name, input riscv_div_isa_pkg::div_op_e op,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                          input logic [XLEN-1:0] exp);
    vecs.push_back({op, a, b, exp});
    vec_names.push_back(name);
  endtask

`include "riscv_div_tb_cases.svh"

  //////////////////////////////
  // checks
  //////////////////////////////
  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] got);
    n_checks++;
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s expected %h actual %h", name, exp, got);
      n_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    n_checks++;
    assert (cond === 1'b1)
    else
    begin
      $display("ERROR %s", msg);
      n_errors++;
    end
  endtask

  //////////////////////////////
  // isa reference
  //////////////////////////////
  function automatic logic is_signed_op(input riscv_div_isa_pkg::div_op_e op);
    return (op == riscv_div_isa_pkg::OP_DIV) || (op == riscv_div_isa_pkg::OP_REM);
  endfunction

  // divide by zero or signed overflow, one-cycle answer
  function automatic logic expects_special(input riscv_div_isa_pkg::div_op_e op,
                                           input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    return (b == '0) || (is_signed_op(op) && (a == MIN_NEG) && (b == '1));
  endfunction

  function automatic logic [XLEN-1:0] ref_result(input riscv_div_isa_pkg::div_op_e op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic is_rem;
    is_rem = (op == riscv_div_isa_pkg::OP_REM) || (op == riscv_div_isa_pkg::OP_REMU);
    if (b == '0)
      return is_rem ? a : '1;         // quotient all ones, remainder = dividend
    if (expects_special(op, a, b))
      return is_rem ? '0 : MIN_NEG;   // overflow
    case (op)
      riscv_div_isa_pkg::OP_DIV:  return $signed(a) / $signed(b);  // truncates toward zero
      riscv_div_isa_pkg::OP_REM:  return $signed(a) % $signed(b);  // sign of dividend
      riscv_div_isa_pkg::OP_DIVU: return a / b;
      default:                    return a % b;
    endcase
  endfunction

  function automatic riscv_div_isa_pkg::instr_t make_instr(input riscv_div_isa_pkg::div_op_e op);
    riscv_div_isa_pkg::funct3_t f3;
    case (op)
      riscv_div_isa_pkg::OP_DIV:  f3 = riscv_div_isa_pkg::F3_DIV;
      riscv_div_isa_pkg::OP_DIVU: f3 = riscv_div_isa_pkg::F3_DIVU;
      riscv_div_isa_pkg::OP_REM:  f3 = riscv_div_isa_pkg::F3_REM;
      default:                    f3 = riscv_div_isa_pkg::F3_REMU;
    endcase
    // rd x3, rs1 x1, rs2 x2
    return {riscv_div_isa_pkg::FUNCT7_MULDIV, 5'd2, 5'd1, f3, 5'd3,
            riscv_div_isa_pkg::OPC_OP, 2'b11};
  endfunction

  //////////////////////////////
  // drivers
  //////////////////////////////
  task automatic run_case(input string name, input vec_t v, input int hold);
    int   lat = 0;
    int   stall_cnt = 0;
    logic seen = 1'b0;
    logic spec;
    spec = expects_special(v.op, v.a, v.b);
    @(posedge clk);
    #1;
    id_instr  = make_instr(v.op);
    op_a      = v.a;
    op_b      = v.b;
    id_bubble = 1'b0;
    ex_stall  = (hold > 0);  // back-pressure first
    for (int i = 0; i < hold; i++)
    begin
      @(posedge clk);        // edge sees ex_stall high
      #1;
      check_true(!div_stall && div_bubble, {name, ": accepted while ex_stall was high"});
    end
    ex_stall = 1'b0;
    @(posedge clk);           // accepting edge
    #1;
    id_bubble = 1'b1;
    while (!seen && (lat < XLEN + 8))
    begin
      @(negedge clk);
      lat++;
      if (div_stall)
        stall_cnt++;
      seen = !div_bubble;
    end
    if (!seen)
    begin
      check_true(1'b0, {name, ": no result bubble from the DUT"});
      return;
    end
    check_value(name, v.exp, div_r);
    check_value({name, "/latency"}, spec ? 1 : XLEN + 2, lat);
    check_value({name, "/stall_cycles"}, spec ? 0 : XLEN + 1, stall_cnt);
    @(negedge clk);
    check_true(div_bubble && !div_stall, {name, ": bubble low longer than one cycle"});
    last_r = v.exp;
  endtask

  // non-divide word, DUT must stay quiet
  task automatic run_ignored(input string name, input riscv_div_isa_pkg::instr_t instr);
    @(posedge clk);
    #1;
    id_instr  = instr;
    id_bubble = 1'b0;
    @(posedge clk);
    #1;
    id_bubble = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      check_true(!div_stall && div_bubble, {name, ": DUT reacted to a non-divide instruction"});
    end
    check_value(name, last_r, div_r);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial
  begin
    vec_t v;
    int   sel;
    void'($urandom(32'hf4bc_e7ed));  // seed once
    rstn      = 1'b0;
    ex_stall  = 1'b0;
    id_bubble = 1'b1;
    id_instr  = '0;
    op_a      = '0;
    op_b      = '0;
    n_checks  = 0;
    n_errors  = 0;
    last_r    = '0;
    loaded    = 1'b0;
    load_directed_cases();
    loaded = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    check_true(!div_stall && div_bubble && (uut.u_fsm.state_q == riscv_div_ctl_pkg::ST_CHK),
               "DUT not idle after reset");
    foreach (vecs[i])
    begin
      run_case(vec_names[i], vecs[i], i % 4);
    end
    run_ignored("xor_funct7_zero", {7'd0, 5'd2, 5'd1, riscv_div_isa_pkg::F3_DIV, 5'd3,
                                    riscv_div_isa_pkg::OPC_OP, 2'b11});
    run_ignored("divw_word_form", {riscv_div_isa_pkg::FUNCT7_MULDIV, 5'd2, 5'd1,
                                   riscv_div_isa_pkg::F3_DIV, 5'd3,
                                   riscv_div_isa_pkg::OPC_OP_64, 2'b11});
    run_ignored("mul", {riscv_div_isa_pkg::FUNCT7_MULDIV, 5'd2, 5'd1, 3'b000, 5'd3,
                        riscv_div_isa_pkg::OPC_OP, 2'b11});
    for (int i = 0; i < 200; i++)
    begin
      v.op = riscv_div_isa_pkg::div_op_e'($urandom_range(0, 3));
      v.a  = $urandom;
      v.b  = $urandom;
      sel  = $urandom_range(0, 9);
      if (sel == 0)
        v.b = '0;              // divide by zero
      else if (sel == 1)
      begin
        v.a = MIN_NEG;         // overflow pair
        v.b = '1;
      end
      else if (sel == 2)
        v.b = $urandom_range(1, 15);
      v.exp = ref_result(v.op, v.a, v.b);
      run_case($sformatf("rand_%0d", i), v, $urandom_range(0, 2));
    end
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // watchdog, sized from the case count
  initial
  begin
    int limit;
    wait (loaded);
    limit = (vecs.size() + 210) * 40;
    repeat (limit) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- riscv_div.f
+incdir+include
logic/riscv_div_isa_pkg.sv
logic/riscv_div_ctl_pkg.sv
logic/riscv_div_decode.sv
logic/riscv_div_fsm.sv
logic/riscv_div_step_counter.sv
logic/riscv_div_restoring_core.sv
logic/riscv_div_result.sv
logic/riscv_div_top.sv
test/riscv_div_tb.sv

//--- Makefile
TOP := riscv_div_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f riscv_div.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
